// ==== bench/dcache_tests.txt ====
// opcode address data expected, all hex
// 1 load, 2 store, 3 LL, 4 SC, 5 halt, 6 memory word check
1 00000108 00000000 5a5ac2cb // cold miss, refill
1 00000108 00000000 5a5ac2cb // repeat hits
1 0000010c 00000000 5a5ac2cf
2 0000010c 11112222 00000000 // store hit
1 0000010c 00000000 11112222
2 00000010 aaaa0001 00000000 // set 2, miss then dirty
1 00000050 00000000 5a5ac393 // fills other way
1 00000090 00000000 5a5ac353 // evicts dirty LRU
6 00000010 00000000 aaaa0001
6 00000014 00000000 5a5ac3d7
1 00000010 00000000 aaaa0001 // reload victim
3 00000018 00000000 5a5ac3db // LL
4 00000018 5c5c0001 00000001 // SC succeeds
1 00000018 00000000 5c5c0001
3 0000001c 00000000 5a5ac3df
2 0000001c 77770001 00000000 // breaks the link
4 0000001c deadbeef 00000000 // SC fails
1 0000001c 00000000 77770001
5 00000000 00000000 00000000 // flush
6 0000010c 00000000 11112222
6 00000108 00000000 5a5ac2cb
6 00000010 00000000 aaaa0001
6 00000018 00000000 5c5c0001
6 0000001c 00000000 77770001

// ==== tb.f ====
+incdir+hdl
hdl/cache_geom_pkg.sv
hdl/mem_bus_pkg.sv
hdl/way_array.sv
hdl/dcache_lookup.sv
hdl/dcache_ctrl.sv
hdl/dcache_response.sv
hdl/dcache_top.sv
bench/dcache_properties.sv
bench/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/dcache_tb.sv ====
module dcache_tb;

    localparam logic [31:0] FILL_KEY = 32'h5a5a_c3c3;
    localparam int MAX_LINES       = 64;
    localparam int CYCLES_PER_LINE = 200;

    logic               CLK;
    logic               nRST;
    logic               dmemREN;
    logic               dmemWEN;
    logic               datomic;
    logic               halt;
    mem_bus_pkg::word_t dmemaddr;
    mem_bus_pkg::word_t dmemstore;
    mem_bus_pkg::word_t dmemload;
    logic               dhit;
    logic               flushed;
    logic               dREN;
    logic               dWEN;
    logic               dwait;
    mem_bus_pkg::word_t daddr;
    mem_bus_pkg::word_t dstore;
    mem_bus_pkg::word_t dload;

    logic [31:0] tests [4*MAX_LINES];
    logic [31:0] mem_words [logic [31:0]];
    logic [31:0] rng_state;
    logic [1:0]  wait_left;
    int          n_lines;
    int          cycles;
    int          errors;

    dcache_top dut_i (
        .CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .datomic(datomic),
        .halt(halt), .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dhit(dhit),
        .dmemload(dmemload), .flushed(flushed), .dREN(dREN), .dWEN(dWEN), .daddr(daddr),
        .dstore(dstore), .dload(dload), .dwait(dwait)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Untouched words read back a pattern of their own address
    function automatic logic [31:0] mem_read(input logic [31:0] a);
        if (mem_words.exists(a)) return mem_words[a];
        return a ^ FILL_KEY;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic issue_request(input logic ren, input logic wen, input logic atomic,
                                 input logic [31:0] addr, input logic [31:0] data,
                                 output logic [31:0] load);
        @(posedge CLK);
        dmemREN   <= ren;
        dmemWEN   <= wen;
        datomic   <= atomic;
        dmemaddr  <= addr;
        dmemstore <= data;
        do begin
            @(negedge CLK);
        end while (!dhit);
        load = dmemload; // Stable mid-cycle
        @(posedge CLK);
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;
        datomic <= 1'b0;
    endtask

    task automatic halt_until_flushed();
        @(posedge CLK);
        halt <= 1'b1;
        do begin
            @(negedge CLK);
        end while (!flushed);
        @(posedge CLK);
        halt <= 1'b0;
    endtask

    // Main memory serving one word per request with random extra wait cycles
    initial begin : memory_model
        dwait     <= 1'b1;
        dload     <= '0;
        wait_left <= 2'd0;
        rng_state <= 32'hc188;
        forever begin
            @(posedge CLK);
            if (nRST && (dREN || dWEN)) begin
                if (!dwait) begin // Word completes at this edge
                    if (dWEN) mem_words[daddr] = dstore;
                    dwait     <= 1'b1;
                    rng_state <= xorshift32(rng_state);
                    wait_left <= rng_state[1:0];
                end else if (wait_left == 2'd0) begin
                    dwait <= 1'b0;
                    dload <= mem_read(daddr);
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] opcode;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] want;
        logic [31:0] load;
        nRST      <= 1'b0;
        dmemREN   <= 1'b0;
        dmemWEN   <= 1'b0;
        datomic   <= 1'b0;
        halt      <= 1'b0;
        dmemaddr  <= '0;
        dmemstore <= '0;
        errors = 0;
        for (int i = 0; i < 4*MAX_LINES; i++) tests[i] = '0;
        $readmemh("bench/dcache_tests.txt", tests);
        n_lines = 0;
        while (n_lines < MAX_LINES && tests[4*n_lines] != 0) n_lines++;
        if (n_lines == 0) begin
            errors++;
            $display("No test lines could be read from the data file");
        end
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        // dhit, dREN, dWEN, flushed
        compare_word("outputs after reset", {28'b0, dhit, dREN, dWEN, flushed}, 32'h0);
        for (int k = 0; k < n_lines; k++) begin
            opcode = tests[4*k];
            addr   = tests[4*k+1];
            data   = tests[4*k+2];
            want   = tests[4*k+3];
            case (opcode)
                1: begin
                    issue_request(1'b1, 1'b0, 1'b0, addr, data, load);
                    compare_word($sformatf("load %h", addr), load, want);
                end
                2: issue_request(1'b0, 1'b1, 1'b0, addr, data, load);
                3: begin
                    issue_request(1'b1, 1'b0, 1'b1, addr, data, load);
                    compare_word($sformatf("LL %h", addr), load, want);
                end
                4: begin
                    issue_request(1'b0, 1'b1, 1'b1, addr, data, load);
                    compare_word($sformatf("SC %h", addr), load, want);
                end
                5: halt_until_flushed();
                6: compare_word($sformatf("memory %h", addr), mem_read(addr), want);
                default: begin
                    errors++;
                    $display("Test line %0d has an unknown opcode %0h", k, opcode);
                end
            endcase
        end
        $display("%0d errors in %0d test lines", errors, n_lines);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        wait (nRST === 1'b1);
        while (cycles < CYCLES_PER_LINE * n_lines) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", cycles);
        $display("%0d errors in %0d test lines", errors, n_lines);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== bench/dcache_properties.sv ====
module dcache_properties (
    input logic               CLK,
    input logic               nRST,
    input logic               dREN,
    input logic               dWEN,
    input logic               dwait,
    input logic               flushed,
    input mem_bus_pkg::word_t daddr
);

    // One bus direction at a time
    assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
        else $error("dREN and dWEN are high together");

    // Halted until reset
    assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else $error("flushed dropped after rising");

    // Stalled request keeps its address
    assert property (@(posedge CLK) disable iff (!nRST)
        (dREN || dWEN) && dwait |=> $stable(daddr))
        else $error("daddr changed while the request was stalled");

endmodule

bind dcache_top dcache_properties props_i (
    .CLK(CLK),
    .nRST(nRST),
    .dREN(dREN),
    .dWEN(dWEN),
    .dwait(dwait),
    .flushed(flushed),
    .daddr(daddr)
);

// ==== hdl/dcache_top.sv ====
`include "dcache_defs.svh"

module dcache_top (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               dmemREN,
    input  logic               dmemWEN,
    input  logic               datomic,
    input  logic               halt,
    input  mem_bus_pkg::word_t dmemaddr,
    input  mem_bus_pkg::word_t dmemstore,
    output logic               dhit,
    output mem_bus_pkg::word_t dmemload,
    output logic               flushed,
    output logic               dREN,
    output logic               dWEN,
    output mem_bus_pkg::word_t daddr,
    output mem_bus_pkg::word_t dstore,
    input  mem_bus_pkg::word_t dload,
    input  logic               dwait
);

    logic [`DCACHE_IDX_W-1:0] arr_idx;
    logic                     tag_wen_l, tag_wen_r, data_wen_l, data_wen_r;
    cache_geom_pkg::entry_t   new_entry, tag_l, tag_r;
    cache_geom_pkg::block_t   new_block, data_l, data_r, hit_block, merged;
    logic                     hit, hit_way, victim_way, victim_dirty, lru, link_ok;
    logic [`DCACHE_TAG_W-1:0] victim_tag;

    way_array #(.payload_t(cache_geom_pkg::entry_t)) tag_l_i (
        .CLK(CLK), .nRST(nRST), .idx(arr_idx), .wen(tag_wen_l), .wdata(new_entry), .rdata(tag_l)
    );
    way_array #(.payload_t(cache_geom_pkg::entry_t)) tag_r_i (
        .CLK(CLK), .nRST(nRST), .idx(arr_idx), .wen(tag_wen_r), .wdata(new_entry), .rdata(tag_r)
    );
    way_array #(.payload_t(cache_geom_pkg::block_t)) data_l_i (
        .CLK(CLK), .nRST(nRST), .idx(arr_idx), .wen(data_wen_l), .wdata(new_block),
        .rdata(data_l)
    );
    way_array #(.payload_t(cache_geom_pkg::block_t)) data_r_i (
        .CLK(CLK), .nRST(nRST), .idx(arr_idx), .wen(data_wen_r), .wdata(new_block),
        .rdata(data_r)
    );

    dcache_lookup lookup_i (
        .addr(cache_geom_pkg::addr_t'(dmemaddr)), .entry_l(tag_l), .entry_r(tag_r), .lru(lru),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    dcache_ctrl ctrl_i (
        .CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .datomic(datomic),
        .halt(halt), .addr(cache_geom_pkg::addr_t'(dmemaddr)), .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .tag_l(tag_l), .tag_r(tag_r), .data_l(data_l), .data_r(data_r), .merged(merged),
        .dload(dload), .dwait(dwait), .dhit(dhit), .flushed(flushed), .dREN(dREN),
        .dWEN(dWEN), .daddr(daddr), .dstore(dstore), .link_ok(link_ok), .hit_block(hit_block),
        .arr_idx(arr_idx), .tag_wen_l(tag_wen_l), .tag_wen_r(tag_wen_r),
        .new_entry(new_entry), .data_wen_l(data_wen_l), .data_wen_r(data_wen_r),
        .new_block(new_block), .lru_out(lru)
    );

    dcache_response response_i (
        .addr(cache_geom_pkg::addr_t'(dmemaddr)), .block(hit_block), .dmemstore(dmemstore),
        .datomic(datomic), .dmemWEN(dmemWEN), .link_ok(link_ok), .dmemload(dmemload),
        .merged(merged)
    );

endmodule

// ==== hdl/dcache_response.sv ====
module dcache_response (
    input  cache_geom_pkg::addr_t  addr,
    input  cache_geom_pkg::block_t block,
    input  mem_bus_pkg::word_t     dmemstore,
    input  logic                   datomic,
    input  logic                   dmemWEN,
    input  logic                   link_ok,
    output mem_bus_pkg::word_t     dmemload,
    output cache_geom_pkg::block_t merged
);

    mem_bus_pkg::word_t load_word;

    assign load_word = block[addr.blkoff];

    // SC reports its outcome instead of data
    always_comb begin
        if (dmemWEN && datomic) begin
            dmemload = {31'b0, link_ok};
        end else begin
            dmemload = load_word;
        end
    end

    // Store word lands in the addressed half
    always_comb begin
        merged               = block;
        merged[addr.blkoff]  = dmemstore;
    end

endmodule

// ==== hdl/dcache_ctrl.sv ====
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     dmemREN,
    input  logic                     dmemWEN,
    input  logic                     datomic,
    input  logic                     halt,
    input  cache_geom_pkg::addr_t    addr,
    input  logic                     hit,
    input  logic                     hit_way,
    input  logic                     victim_way,
    input  logic                     victim_dirty,
    input  logic [`DCACHE_TAG_W-1:0] victim_tag,
    input  cache_geom_pkg::entry_t   tag_l,
    input  cache_geom_pkg::entry_t   tag_r,
    input  cache_geom_pkg::block_t   data_l,
    input  cache_geom_pkg::block_t   data_r,
    input  cache_geom_pkg::block_t   merged,
    input  mem_bus_pkg::word_t       dload,
    input  logic                     dwait,
    output logic                     dhit,
    output logic                     flushed,
    output logic                     dREN,
    output logic                     dWEN,
    output mem_bus_pkg::word_t       daddr,
    output mem_bus_pkg::word_t       dstore,
    output logic                     link_ok,
    output cache_geom_pkg::block_t   hit_block,
    output logic [`DCACHE_IDX_W-1:0] arr_idx,
    output logic                     tag_wen_l,
    output logic                     tag_wen_r,
    output cache_geom_pkg::entry_t   new_entry,
    output logic                     data_wen_l,
    output logic                     data_wen_r,
    output cache_geom_pkg::block_t   new_block,
    output logic                     lru_out
);

    localparam int FRAMES = `DCACHE_SETS * `DCACHE_WAYS;

    mem_bus_pkg::ctrl_state_t state, next_state;

    logic [$clog2(FRAMES):0]  frame_cnt, next_cnt;
    logic [`DCACHE_SETS-1:0]  lru_bits, next_lru;
    cache_geom_pkg::addr_t    link_addr;
    logic                     link_valid, next_link_valid;
    logic                     halt_q;

    logic                     sc_fail;
    logic                     store_hit;
    logic                     tag_we, data_we, we_way;
    logic [`DCACHE_IDX_W-1:0] scan_idx;
    logic                     scan_way;
    cache_geom_pkg::entry_t   scan_entry;
    cache_geom_pkg::block_t   scan_block;
    cache_geom_pkg::block_t   victim_block;

    assign link_ok   = link_valid && (link_addr == addr);
    assign sc_fail   = dmemWEN && datomic && !link_ok;
    assign store_hit = dmemWEN && !sc_fail && hit;
    assign lru_out   = lru_bits[addr.idx];

    assign hit_block    = hit_way ? data_r : data_l;
    assign victim_block = victim_way ? data_r : data_l;

    // Flush walks left way first, then right
    assign scan_idx   = frame_cnt[`DCACHE_IDX_W-1:0];
    assign scan_way   = frame_cnt[`DCACHE_IDX_W];
    assign scan_entry = scan_way ? tag_r : tag_l;
    assign scan_block = scan_way ? data_r : data_l;

    always_comb begin
        next_state = state;
        next_cnt   = frame_cnt;
        next_lru   = lru_bits;
        dhit       = 1'b0;
        flushed    = 1'b0;
        dREN       = 1'b0;
        dWEN       = 1'b0;
        daddr      = '0;
        dstore     = '0;
        arr_idx    = addr.idx;
        tag_we     = 1'b0;
        data_we    = 1'b0;
        we_way     = hit_way;
        new_entry  = '{valid: 1'b1, dirty: 1'b1, tag: addr.tag};
        new_block  = merged;

        unique case (state)
            mem_bus_pkg::idle: begin
                if (halt || halt_q) begin
                    next_state = mem_bus_pkg::flush_scan;
                end else if (sc_fail) begin
                    dhit = 1'b1; // Ack with no write
                end else if (dmemREN || dmemWEN) begin
                    if (hit) begin
                        dhit               = 1'b1;
                        next_lru[addr.idx] = ~hit_way;
                        tag_we             = store_hit;
                        data_we            = store_hit;
                    end else if (victim_dirty) begin
                        next_state = mem_bus_pkg::wb0;
                    end else begin
                        next_state = mem_bus_pkg::fill0;
                    end
                end
            end
            mem_bus_pkg::wb0, mem_bus_pkg::wb1: begin
                dWEN = 1'b1;
                if (state == mem_bus_pkg::wb0) begin
                    daddr  = {victim_tag, addr.idx, 1'b0, 2'b00};
                    dstore = victim_block[0];
                    if (!dwait) next_state = mem_bus_pkg::wb1;
                end else begin
                    daddr  = {victim_tag, addr.idx, 1'b1, 2'b00};
                    dstore = victim_block[1];
                    if (!dwait) next_state = mem_bus_pkg::fill0;
                end
            end
            mem_bus_pkg::fill0: begin
                dREN         = 1'b1;
                daddr        = {addr.tag, addr.idx, 1'b0, 2'b00};
                we_way       = victim_way;
                new_block    = victim_block;
                new_block[0] = dload;
                new_entry    = '{valid: 1'b0, dirty: 1'b0, tag: addr.tag}; // Frame in transit
                if (!dwait) begin
                    tag_we     = 1'b1;
                    data_we    = 1'b1;
                    next_state = mem_bus_pkg::fill1;
                end
            end
            mem_bus_pkg::fill1: begin
                dREN         = 1'b1;
                daddr        = {addr.tag, addr.idx, 1'b1, 2'b00};
                we_way       = victim_way;
                new_block    = victim_block;
                new_block[1] = dload;
                new_entry    = '{valid: 1'b1, dirty: 1'b0, tag: addr.tag};
                if (!dwait) begin
                    tag_we     = 1'b1;
                    data_we    = 1'b1;
                    next_state = mem_bus_pkg::idle; // Replay hits
                end
            end
            mem_bus_pkg::flush_scan: begin
                arr_idx = scan_idx;
                if (frame_cnt == FRAMES) begin
                    next_state = mem_bus_pkg::halted;
                end else if (scan_entry.valid && scan_entry.dirty) begin
                    next_state = mem_bus_pkg::flush0;
                end else begin
                    next_cnt = frame_cnt + 1'b1;
                end
            end
            mem_bus_pkg::flush0: begin
                arr_idx = scan_idx;
                dWEN    = 1'b1;
                daddr   = {scan_entry.tag, scan_idx, 1'b0, 2'b00};
                dstore  = scan_block[0];
                if (!dwait) next_state = mem_bus_pkg::flush1;
            end
            mem_bus_pkg::flush1: begin
                arr_idx   = scan_idx;
                dWEN      = 1'b1;
                daddr     = {scan_entry.tag, scan_idx, 1'b1, 2'b00};
                dstore    = scan_block[1];
                we_way    = scan_way;
                new_entry = '{valid: 1'b1, dirty: 1'b0, tag: scan_entry.tag};
                if (!dwait) begin
                    tag_we     = 1'b1; // Frame now clean
                    next_cnt   = frame_cnt + 1'b1;
                    next_state = mem_bus_pkg::flush_scan;
                end
            end
            mem_bus_pkg::halted: begin
                flushed = 1'b1;
            end
            default: next_state = mem_bus_pkg::idle;
        endcase
    end

    assign tag_wen_l  = tag_we && !we_way;
    assign tag_wen_r  = tag_we && we_way;
    assign data_wen_l = data_we && !we_way;
    assign data_wen_r = data_we && we_way;

    // LL arms the link and a completed store to that address disarms it
    always_comb begin
        next_link_valid = link_valid;
        if (dhit && dmemREN && datomic) begin
            next_link_valid = 1'b1;
        end else if (dhit && dmemWEN && link_ok) begin
            next_link_valid = 1'b0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= mem_bus_pkg::idle;
            frame_cnt  <= '0;
            lru_bits   <= '0;
            link_addr  <= '0;
            link_valid <= 1'b0;
            halt_q     <= 1'b0;
        end else begin
            state      <= next_state;
            frame_cnt  <= next_cnt;
            lru_bits   <= next_lru;
            link_valid <= next_link_valid;
            halt_q     <= halt_q || halt;
            if (dhit && dmemREN && datomic) link_addr <= addr;
        end
    end

endmodule

// ==== hdl/dcache_lookup.sv ====
`include "dcache_defs.svh"

module dcache_lookup (
    input  cache_geom_pkg::addr_t    addr,
    input  cache_geom_pkg::entry_t   entry_l,
    input  cache_geom_pkg::entry_t   entry_r,
    input  logic                     lru,
    output logic                     hit,
    output logic                     hit_way,
    output logic                     victim_way,
    output logic                     victim_dirty,
    output logic [`DCACHE_TAG_W-1:0] victim_tag
);

    logic                   hit_l;
    logic                   hit_r;
    cache_geom_pkg::entry_t victim;

    // Tag compare qualified by valid
    assign hit_l = entry_l.valid && (entry_l.tag == addr.tag);
    assign hit_r = entry_r.valid && (entry_r.tag == addr.tag);

    assign hit     = hit_l || hit_r;
    assign hit_way = hit_r; // 0 left, 1 right

    // LRU bit names the way to replace
    assign victim_way = lru;
    assign victim     = lru ? entry_r : entry_l;

    // Only a valid dirty frame needs a write-back
    assign victim_dirty = victim.valid && victim.dirty;
    assign victim_tag   = victim.tag;

endmodule

// ==== hdl/way_array.sv ====
`include "dcache_defs.svh"

module way_array #(
    parameter type payload_t = logic
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [`DCACHE_IDX_W-1:0] idx,
    input  logic                     wen,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [`DCACHE_SETS];

    // Asynchronous read of the indexed set
    assign rdata = mem[idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `DCACHE_SETS; i++) begin
                mem[i] <= '0; // All frames invalid
            end
        end else if (wen) begin
            mem[idx] <= wdata;
        end
    end

endmodule

// ==== hdl/mem_bus_pkg.sv ====
`include "dcache_defs.svh"

package mem_bus_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // Controller states
    typedef enum logic [3:0] {
        idle,
        wb0,
        wb1,
        fill0,
        fill1,
        flush_scan,
        flush0,
        flush1,
        halted
    } ctrl_state_t;

endpackage

// ==== hdl/cache_geom_pkg.sv ====
`include "dcache_defs.svh"

package cache_geom_pkg;

    // Byte address as seen by the cache
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]  tag;
        logic [`DCACHE_IDX_W-1:0]  idx;
        logic [`DCACHE_OFF_W-1:0]  blkoff;
        logic [`DCACHE_BYTE_W-1:0] bytoff;
    } addr_t;

    // Tag array payload for one frame
    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`DCACHE_TAG_W-1:0] tag;
    } entry_t;

    // Data array payload with word 0 in the low half
    typedef logic [`DCACHE_WORDS-1:0][`DCACHE_WORD_W-1:0] block_t;

endpackage

// ==== hdl/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Address split for a 32-bit byte address
`define DCACHE_TAG_W   26
`define DCACHE_IDX_W   3
`define DCACHE_OFF_W   1
`define DCACHE_BYTE_W  2

// Cache geometry
`define DCACHE_SETS    8
`define DCACHE_WAYS    2
`define DCACHE_WORDS   2

// Machine word
`define DCACHE_WORD_W  32

`endif
